/* include/mlaccel_config.svh */
// constants for the inference engine, shared by the RTL and the testbench through `include
`ifndef MLACCEL_CONFIG_SVH
`define MLACCEL_CONFIG_SVH

`define MLACCEL_COEFF_DEPTH 512
`define MLACCEL_MEM_LATENCY 2
// a Store's write is on the memory port this many cycles after its stage 1
`define MLACCEL_STORE_SLOT 7

// instruction fields: maddr, caddr, opcode from the top bit down
`define MLACCEL_MADDR_MSB 31
`define MLACCEL_MADDR_LSB 15
`define MLACCEL_CADDR_MSB 14
`define MLACCEL_CADDR_LSB 6
`define MLACCEL_OPCODE_MSB 5
`define MLACCEL_OPCODE_LSB 0

`define MLACCEL_OP_LOADCOEFF0 6'd5
`define MLACCEL_OP_LOADCOEFF1 6'd6
`define MLACCEL_OP_SETVBP 6'd8
`define MLACCEL_OP_ADDVBP 6'd9
`define MLACCEL_OP_SETSBP 6'd12
`define MLACCEL_OP_ADDSBP 6'd13
`define MLACCEL_OP_SETCBP 6'd14
`define MLACCEL_OP_ADDCBP 6'd15
`define MLACCEL_OP_STORE 6'd16
`define MLACCEL_OP_STORE0 6'd17
`define MLACCEL_OP_STORE1 6'd18
`define MLACCEL_OP_RELU 6'd20
`define MLACCEL_OP_RELU0 6'd21
`define MLACCEL_OP_RELU1 6'd22
`define MLACCEL_OP_MACC 6'd40
`define MLACCEL_OP_MACCZ 6'd42

`endif

/* rtl/mlaccel_pkg.sv */
// common data types of the inference engine, imported by every RTL module
package mlaccel_pkg;

	// one command word as taken from the command port
	typedef logic [31:0] insn_t;

	// memory address field of a command, also the width of VBP and SBP
	typedef logic [16:0] maddr_t;

	// coefficient address field, also CBP and the store shift amount
	typedef logic [8:0] caddr_t;

	typedef logic [5:0] opcode_t;

	// the external memory works on 64-bit words with one enable per byte
	typedef logic [15:0] mem_addr_t;
	typedef logic [63:0] mem_word_t;
	typedef logic [7:0] byte_en_t;

	// lane 0 in the low half and lane 1 in the high half, eight signed bytes each
	typedef logic [127:0] coeff_word_t;

	typedef logic signed [31:0] acc_t;

endpackage

/* rtl/mlaccel_issue.sv */
// command intake, memory port interlock, VBP and the pipeline stage registers
`timescale 1ns/1ps
`include "mlaccel_config.svh"

module mlaccel_issue import mlaccel_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      cmd_valid,
	input  insn_t     cmd_insn,
	output logic      cmd_ready,
	output logic      busy,
	output logic      mem_ren,
	output mem_addr_t read_addr,
	output logic      s3_valid,
	output insn_t     s3_insn,
	output logic      s4_valid,
	output insn_t     s4_insn,
	output logic      s5_valid,
	output insn_t     s5_insn,
	output logic      s6_valid,
	output insn_t     s6_insn
);
	logic s1_valid;
	insn_t s1_insn;
	logic s2_valid;
	insn_t s2_insn;
	opcode_t s1_opcode;
	maddr_t s1_maddr;
	logic read_req;
	logic store_req;
	logic s1_stall;
	logic s1_go;
	maddr_t vbp;
	// bit k set means the memory port is taken k cycles from now
	logic [`MLACCEL_STORE_SLOT:0] slot_res;
	logic [`MLACCEL_STORE_SLOT:0] slot_mask;

	assign s1_opcode = s1_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s1_maddr = s1_insn[`MLACCEL_MADDR_MSB:`MLACCEL_MADDR_LSB];

	always_comb begin
		read_req = 1'b0;
		store_req = 1'b0;
		case (s1_opcode)
			`MLACCEL_OP_LOADCOEFF0, `MLACCEL_OP_LOADCOEFF1,
			`MLACCEL_OP_MACC, `MLACCEL_OP_MACCZ: read_req = s1_valid;
			`MLACCEL_OP_STORE, `MLACCEL_OP_STORE0, `MLACCEL_OP_STORE1,
			`MLACCEL_OP_RELU, `MLACCEL_OP_RELU0, `MLACCEL_OP_RELU1: store_req = s1_valid;
			default: ;
		endcase
		slot_mask = '0;
		slot_mask[1] = read_req;
		slot_mask[`MLACCEL_STORE_SLOT] = store_req;
	end

	assign s1_stall = |(slot_res & slot_mask);
	assign s1_go = s1_valid && !s1_stall;
	assign cmd_ready = !s1_stall;

	// pending slots keep busy up until the last write is on the port
	assign busy = s1_valid || s2_valid || s3_valid || s4_valid || s5_valid || s6_valid ||
		(|slot_res);

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_res <= '0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
			s5_valid <= 1'b0;
			s6_valid <= 1'b0;
			mem_ren <= 1'b0;
			read_addr <= '0;
			vbp <= '0;
		end else begin
			slot_res <= (slot_res | (s1_go ? slot_mask : '0)) >> 1;
			if (!s1_stall) begin
				s1_valid <= cmd_valid;
			end
			// a stalled stage 1 leaves a bubble behind in stage 2
			s2_valid <= s1_go;
			s3_valid <= s2_valid;
			s4_valid <= s3_valid;
			s5_valid <= s4_valid;
			s6_valid <= s5_valid;
			mem_ren <= s1_go && read_req;
			read_addr <= '0;
			if (s1_go && read_req) begin
				if (s1_opcode == `MLACCEL_OP_MACC || s1_opcode == `MLACCEL_OP_MACCZ) begin
					read_addr <= mem_addr_t'(s1_maddr + vbp);
				end else begin
					read_addr <= mem_addr_t'(s1_maddr);
				end
			end
			if (s1_go && s1_opcode == `MLACCEL_OP_SETVBP) begin
				vbp <= s1_maddr;
			end
			if (s1_go && s1_opcode == `MLACCEL_OP_ADDVBP) begin
				vbp <= vbp + s1_maddr;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!s1_stall) begin
			s1_insn <= cmd_insn;
		end
		s2_insn <= s1_insn;
		s3_insn <= s2_insn;
		s4_insn <= s3_insn;
		s5_insn <= s4_insn;
		s6_insn <= s5_insn;
	end

	// the cycle claimed by a store must never see a read issued into it
	assert property (@(posedge clock) disable iff (reset)
		(s1_go && store_req) |-> ##`MLACCEL_STORE_SLOT !mem_ren);

endmodule

/* rtl/mlaccel_coeff_store.sv */
// coefficient memory with CBP, read relative to CBP and loaded from the memory port
`timescale 1ns/1ps
`include "mlaccel_config.svh"

module mlaccel_coeff_store import mlaccel_pkg::*; #(
	parameter int depth = `MLACCEL_COEFF_DEPTH
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        s3_valid,
	input  insn_t       s3_insn,
	input  logic        s4_valid,
	input  insn_t       s4_insn,
	input  mem_word_t   mem_rdata,
	output coeff_word_t coeff
);
	localparam int index_bits = $clog2(depth);

	coeff_word_t coeff_mem [depth];
	caddr_t cbp;
	opcode_t s3_opcode;
	caddr_t s3_caddr;
	opcode_t s4_opcode;
	caddr_t s4_caddr;
	caddr_t rd_caddr;
	logic [index_bits-1:0] rd_index;
	logic [index_bits-1:0] wr_index;

	assign s3_opcode = s3_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s3_caddr = s3_insn[`MLACCEL_CADDR_MSB:`MLACCEL_CADDR_LSB];
	assign s4_opcode = s4_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s4_caddr = s4_insn[`MLACCEL_CADDR_MSB:`MLACCEL_CADDR_LSB];

	// the read wraps around the store, loads use the plain address
	assign rd_caddr = s4_caddr + cbp;
	assign rd_index = index_bits'(rd_caddr);
	assign wr_index = index_bits'(s4_caddr);

	// read in stage 4 so that a load one cycle ahead is already visible
	assign coeff = coeff_mem[rd_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			cbp <= '0;
		end else if (s3_valid && s3_opcode == `MLACCEL_OP_SETCBP) begin
			cbp <= s3_caddr;
		end else if (s3_valid && s3_opcode == `MLACCEL_OP_ADDCBP) begin
			cbp <= cbp + s3_caddr;
		end
	end

	always_ff @(posedge clock) begin
		if (s4_valid && s4_opcode == `MLACCEL_OP_LOADCOEFF0) begin
			coeff_mem[wr_index][63:0] <= mem_rdata;
		end
		if (s4_valid && s4_opcode == `MLACCEL_OP_LOADCOEFF1) begin
			coeff_mem[wr_index][127:64] <= mem_rdata;
		end
	end

endmodule

/* rtl/mlaccel_mac_array.sv */
// eight-lane signed byte multiply, per-lane adder tree and the two accumulators
`timescale 1ns/1ps
`include "mlaccel_config.svh"

module mlaccel_mac_array import mlaccel_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  insn_t       s4_insn,
	input  logic        s6_valid,
	input  insn_t       s6_insn,
	input  mem_word_t   mem_rdata,
	input  coeff_word_t coeff,
	output acc_t        acc0,
	output acc_t        acc1
);
	logic signed [15:0] prod [2][8];
	acc_t pair_sum [2][4];
	acc_t quad_sum [2][2];
	acc_t lane_sum [2];
	acc_t acc [2];
	opcode_t s4_opcode;
	opcode_t s6_opcode;
	logic s4_mac;

	assign s4_opcode = s4_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s6_opcode = s6_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s4_mac = (s4_opcode == `MLACCEL_OP_MACC) || (s4_opcode == `MLACCEL_OP_MACCZ);

	// the products only move for a MACC, so they stay put for the sums behind it
	always_ff @(posedge clock) begin
		if (s4_mac) begin
			for (int lane = 0; lane < 2; lane++) begin
				for (int i = 0; i < 8; i++) begin
					prod[lane][i] <= $signed(mem_rdata[8*i +: 8]) *
						$signed(coeff[64*lane + 8*i +: 8]);
				end
			end
		end
	end

	// three levels of adders per lane, the last one registered in stage 5
	always_comb begin
		for (int lane = 0; lane < 2; lane++) begin
			for (int j = 0; j < 4; j++) begin
				pair_sum[lane][j] = acc_t'(prod[lane][2*j]) + acc_t'(prod[lane][2*j+1]);
			end
			for (int j = 0; j < 2; j++) begin
				quad_sum[lane][j] = pair_sum[lane][2*j] + pair_sum[lane][2*j+1];
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int lane = 0; lane < 2; lane++) begin
			lane_sum[lane] <= quad_sum[lane][0] + quad_sum[lane][1];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int lane = 0; lane < 2; lane++) begin
				acc[lane] <= '0;
			end
		end else if (s6_valid) begin
			for (int lane = 0; lane < 2; lane++) begin
				// MACCZ starts a fresh sum
				if (s6_opcode == `MLACCEL_OP_MACCZ) begin
					acc[lane] <= lane_sum[lane];
				end else if (s6_opcode == `MLACCEL_OP_MACC) begin
					acc[lane] <= acc[lane] + lane_sum[lane];
				end
			end
		end
	end

	assign acc0 = acc[0];
	assign acc1 = acc[1];

endmodule

/* rtl/mlaccel_store_unit.sv */
// output stage with shift, int8 saturation, ReLU, SBP and byte placement of memory writes
`timescale 1ns/1ps
`include "mlaccel_config.svh"

module mlaccel_store_unit import mlaccel_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      s6_valid,
	input  insn_t     s6_insn,
	input  acc_t      acc0,
	input  acc_t      acc1,
	output byte_en_t  mem_wen,
	output mem_addr_t write_addr,
	output mem_word_t mem_wdata
);
	opcode_t s6_opcode;
	logic s6_relu;
	logic s7_valid;
	opcode_t s7_opcode;
	maddr_t s7_maddr;
	logic [7:0] s7_byte [2];
	maddr_t sbp;
	maddr_t byte_addr;
	logic [2:0] lane;
	logic [1:0] unit_en;

	function automatic logic [7:0] to_int8(acc_t value, caddr_t shift, logic zero_neg);
		acc_t shifted;
		shifted = value >>> shift;
		if (zero_neg && shifted < 0) return 8'h00;
		if (shifted > 127) return 8'h7f;
		if (shifted < -128) return 8'h80;
		return shifted[7:0];
	endfunction

	assign s6_opcode = s6_insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB];
	assign s6_relu = (s6_opcode == `MLACCEL_OP_RELU) || (s6_opcode == `MLACCEL_OP_RELU0) ||
		(s6_opcode == `MLACCEL_OP_RELU1);

	always_ff @(posedge clock) begin
		if (reset) begin
			s7_valid <= 1'b0;
		end else begin
			s7_valid <= s6_valid;
		end
	end

	// the accumulators are sampled here, after every earlier MACC has landed
	always_ff @(posedge clock) begin
		s7_opcode <= s6_opcode;
		s7_maddr <= s6_insn[`MLACCEL_MADDR_MSB:`MLACCEL_MADDR_LSB];
		s7_byte[0] <= to_int8(acc0, s6_insn[`MLACCEL_CADDR_MSB:`MLACCEL_CADDR_LSB], s6_relu);
		s7_byte[1] <= to_int8(acc1, s6_insn[`MLACCEL_CADDR_MSB:`MLACCEL_CADDR_LSB], s6_relu);
	end

	always_comb begin
		case (s7_opcode)
			`MLACCEL_OP_STORE, `MLACCEL_OP_RELU: unit_en = 2'b11;
			`MLACCEL_OP_STORE0, `MLACCEL_OP_RELU0: unit_en = 2'b01;
			`MLACCEL_OP_STORE1, `MLACCEL_OP_RELU1: unit_en = 2'b10;
			default: unit_en = 2'b00;
		endcase
	end

	// unit 1 sits one byte above unit 0 and falls off the word at lane 7
	assign byte_addr = s7_maddr + sbp;
	assign lane = byte_addr[2:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			sbp <= '0;
			mem_wen <= '0;
			write_addr <= '0;
		end else begin
			mem_wen <= '0;
			write_addr <= '0;
			if (s7_valid && s7_opcode == `MLACCEL_OP_SETSBP) begin
				sbp <= s7_maddr;
			end
			if (s7_valid && s7_opcode == `MLACCEL_OP_ADDSBP) begin
				sbp <= byte_addr;
			end
			if (s7_valid && |unit_en) begin
				mem_wen <= {6'b0, unit_en} << lane;
				write_addr <= mem_addr_t'(byte_addr >> 3);
			end
		end
	end

	always_ff @(posedge clock) begin
		mem_wdata <= mem_word_t'({s7_byte[1], s7_byte[0]}) << (8 * lane);
	end

	assert property (@(posedge clock) reset |=> mem_wen == '0);

endmodule

/* rtl/mlaccel_compute.sv */
// top level of the inference engine, connects the pipeline units to the command and memory ports
`timescale 1ns/1ps

module mlaccel_compute import mlaccel_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      cmd_valid,
	input  insn_t     cmd_insn,
	input  mem_word_t mem_rdata,
	output logic      busy,
	output logic      cmd_ready,
	output logic      mem_ren,
	output byte_en_t  mem_wen,
	output mem_addr_t mem_addr,
	output mem_word_t mem_wdata
);
	logic s3_valid;
	insn_t s3_insn;
	logic s4_valid;
	insn_t s4_insn;
	logic s6_valid;
	insn_t s6_insn;
	mem_addr_t read_addr;
	mem_addr_t write_addr;
	coeff_word_t coeff;
	acc_t acc0;
	acc_t acc1;

	// both sources are zero while idle and never active together
	assign mem_addr = read_addr | write_addr;

	mlaccel_issue mlaccel_issue_inst (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_insn  (cmd_insn),
		.cmd_ready (cmd_ready),
		.busy      (busy),
		.mem_ren   (mem_ren),
		.read_addr (read_addr),
		.s3_valid  (s3_valid),
		.s3_insn   (s3_insn),
		.s4_valid  (s4_valid),
		.s4_insn   (s4_insn),
		// nothing at this level works in stage 5
		.s5_valid  (),
		.s5_insn   (),
		.s6_valid  (s6_valid),
		.s6_insn   (s6_insn)
	);

	mlaccel_coeff_store mlaccel_coeff_store_inst (
		.clock     (clock),
		.reset     (reset),
		.s3_valid  (s3_valid),
		.s3_insn   (s3_insn),
		.s4_valid  (s4_valid),
		.s4_insn   (s4_insn),
		.mem_rdata (mem_rdata),
		.coeff     (coeff)
	);

	mlaccel_mac_array mlaccel_mac_array_inst (
		.clock     (clock),
		.reset     (reset),
		.s4_insn   (s4_insn),
		.s6_valid  (s6_valid),
		.s6_insn   (s6_insn),
		.mem_rdata (mem_rdata),
		.coeff     (coeff),
		.acc0      (acc0),
		.acc1      (acc1)
	);

	mlaccel_store_unit mlaccel_store_unit_inst (
		.clock      (clock),
		.reset      (reset),
		.s6_valid   (s6_valid),
		.s6_insn    (s6_insn),
		.acc0       (acc0),
		.acc1       (acc1),
		.mem_wen    (mem_wen),
		.write_addr (write_addr),
		.mem_wdata  (mem_wdata)
	);

endmodule

/* testbench/mlaccel_checker.sv */
// testbench monitor of the inference engine, checks reset state, port rules and every memory write
`timescale 1ns/1ps

module mlaccel_checker import mlaccel_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      busy,
	input  logic      cmd_valid,
	input  logic      cmd_ready,
	input  logic      mem_ren,
	input  byte_en_t  mem_wen,
	input  mem_addr_t mem_addr,
	input  mem_word_t mem_wdata,
	output int        error_count
);
	mem_addr_t exp_addr [$];
	byte_en_t exp_wen [$];
	mem_word_t exp_data [$];
	mem_word_t mask;
	int test_errors;
	int tests_run;
	int tests_failed;
	logic reset_seen;
	logic cmd_waiting;

	initial begin
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_seen = 1'b0;
		cmd_waiting = 1'b0;
	end

	// only the enabled byte lanes of a write carry data
	function automatic mem_word_t lane_mask(byte_en_t wen);
		mem_word_t result;
		for (int i = 0; i < 8; i++) begin
			result[8*i +: 8] = {8{wen[i]}};
		end
		return result;
	endfunction

	task automatic count_error();
		test_errors++;
		error_count++;
	endtask

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] got);
		if (got !== expected) begin
			$display("Error %s expected %h got %h", name, expected, got);
			count_error();
		end
	endtask

	task automatic expect_write(mem_addr_t addr, byte_en_t wen, mem_word_t data);
		exp_addr.push_back(addr);
		exp_wen.push_back(wen);
		exp_data.push_back(data);
	endtask

	// writes still expected when the pipeline has gone idle never came
	task automatic close_test(string name);
		while (exp_addr.size() > 0) begin
			$display("write to word %h never happened in test %s", exp_addr[0], name);
			count_error();
			void'(exp_addr.pop_front());
			void'(exp_wen.pop_front());
			void'(exp_data.pop_front());
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s ok", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic report_counts();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
	endtask

	always @(posedge clock) begin
		// the first cycle after reset shows the idle state
		if (reset_seen && !reset) begin
			check_value("busy", 64'd0, busy);
			check_value("mem_ren", 64'd0, mem_ren);
			check_value("mem_wen", 64'd0, mem_wen);
			check_value("cmd_ready", 64'd1, cmd_ready);
		end
		reset_seen = reset;
		if (!reset) begin
			if (mem_ren && mem_wen != '0) begin
				$display("memory port has a read and a write in the same cycle");
				count_error();
			end
			if (cmd_waiting && !cmd_valid) begin
				$display("cmd_valid dropped while the command was still waiting");
				count_error();
			end
			if (mem_wen != '0) begin
				if (exp_addr.size() == 0) begin
					$display("unexpected write to word %h", mem_addr);
					count_error();
				end else begin
					mask = lane_mask(exp_wen[0]);
					check_value("mem_addr", exp_addr[0], mem_addr);
					check_value("mem_wen", exp_wen[0], mem_wen);
					check_value("mem_wdata", exp_data[0] & mask, mem_wdata & mask);
					void'(exp_addr.pop_front());
					void'(exp_wen.pop_front());
					void'(exp_data.pop_front());
				end
			end
		end
		cmd_waiting = cmd_valid && !cmd_ready && !reset;
	end

endmodule

/* testbench/mlaccel_tb.sv */
// testbench of the inference engine, runs the command sequences of the tests file on a memory model
`timescale 1ns/1ps
`include "mlaccel_config.svh"

module mlaccel_tb import mlaccel_pkg::*; ();
	logic clock;
	logic reset;
	logic cmd_valid;
	insn_t cmd_insn;
	mem_word_t mem_rdata;
	logic busy;
	logic cmd_ready;
	logic mem_ren;
	byte_en_t mem_wen;
	mem_addr_t mem_addr;
	mem_word_t mem_wdata;
	int error_count;
	mem_word_t mem [65536];
	logic read_pending;
	mem_addr_t read_addr_q;
	byte rec_kind [$];
	string rec_name [$];
	logic [63:0] rec_a [$];
	logic [63:0] rec_b [$];
	logic [63:0] rec_c [$];
	int command_count;
	int cycle_limit;
	int cycles;
	logic file_ok;
	logic [31:0] lfsr_state;
	string test_name;

	mlaccel_compute mlaccel_compute_inst (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_insn  (cmd_insn),
		.mem_rdata (mem_rdata),
		.busy      (busy),
		.cmd_ready (cmd_ready),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	mlaccel_checker mlaccel_checker_inst (
		.clock       (clock),
		.reset       (reset),
		.busy        (busy),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.mem_ren     (mem_ren),
		.mem_wen     (mem_wen),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.error_count (error_count)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic next_gap(output int gap);
		lfsr_state = lfsr_step(lfsr_state);
		gap = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		gap = 2 * gap + lfsr_state[0];
	endtask

	task automatic fill_memory();
		logic [15:0] addr;
		for (int i = 0; i < 65536; i++) begin
			addr = i[15:0];
			mem[i] = {addr, ~addr, addr ^ 16'h5a5a, {addr[7:0], addr[15:8]}};
		end
	endtask

	task automatic read_tests();
		int fd;
		string line;
		string name;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] c;
		insn_t insn;
		fd = $fopen("testbench/mlaccel_tests.txt", "r");
		file_ok = (fd != 0);
		if (!file_ok) begin
			$display("cannot open testbench/mlaccel_tests.txt");
		end
		while (file_ok && $fgets(line, fd) > 0) begin
			case (line[0])
				"m": begin
					void'($sscanf(line, "m %h %h", a, b));
					mem[a[15:0]] = b;
				end
				"t": begin
					void'($sscanf(line, "t %s", name));
					rec_kind.push_back("t");
					rec_name.push_back(name);
					rec_a.push_back('0);
					rec_b.push_back('0);
					rec_c.push_back('0);
				end
				"c", "w": begin
					if (line[0] == "c") begin
						void'($sscanf(line, "c %d %d %h", a, b, c));
						insn = '0;
						insn[`MLACCEL_OPCODE_MSB:`MLACCEL_OPCODE_LSB] = a[5:0];
						insn[`MLACCEL_CADDR_MSB:`MLACCEL_CADDR_LSB] = b[8:0];
						insn[`MLACCEL_MADDR_MSB:`MLACCEL_MADDR_LSB] = c[16:0];
						a = insn;
						command_count++;
					end else begin
						void'($sscanf(line, "w %h %h %h", a, b, c));
					end
					rec_kind.push_back(line[0]);
					rec_name.push_back("");
					rec_a.push_back(a);
					rec_b.push_back(b);
					rec_c.push_back(c);
				end
				default: ;
			endcase
		end
		if (file_ok) begin
			$fclose(fd);
		end
	endtask

	task automatic send_command(insn_t insn);
		int gap;
		next_gap(gap);
		if (gap > 0) begin
			cmd_valid <= 1'b0;
			repeat (gap) @(posedge clock);
		end
		cmd_valid <= 1'b1;
		cmd_insn <= insn;
		@(posedge clock);
		while (!cmd_ready) @(posedge clock);
	endtask

	task automatic wait_idle();
		cmd_valid <= 1'b0;
		@(posedge clock);
		while (busy) @(posedge clock);
	endtask

	// memory model, read data shows up two cycles after mem_ren
	always @(posedge clock) begin
		read_pending <= mem_ren;
		read_addr_q <= mem_addr;
		if (read_pending) begin
			mem_rdata <= mem[read_addr_q];
		end
		for (int i = 0; i < 8; i++) begin
			if (mem_wen[i]) begin
				mem[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
			end
		end
	end

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		mem_rdata = '0;
		read_pending = 1'b0;
		read_addr_q = '0;
		command_count = 0;
		lfsr_state = 32'h3cbe0f57;
		test_name = "";
		fill_memory();
		read_tests();
		cycle_limit = 16 * command_count + 200;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		for (int i = 0; i < rec_kind.size(); i++) begin
			if (rec_kind[i] == "t") begin
				if (test_name != "") begin
					wait_idle();
					mlaccel_checker_inst.close_test(test_name);
				end
				test_name = rec_name[i];
				for (int j = i + 1; j < rec_kind.size() && rec_kind[j] != "t"; j++) begin
					if (rec_kind[j] == "w") begin
						mlaccel_checker_inst.expect_write(rec_a[j][15:0], rec_b[j][7:0], rec_c[j]);
					end
				end
			end else if (rec_kind[i] == "c") begin
				send_command(rec_a[i][31:0]);
			end
		end
		if (test_name != "") begin
			wait_idle();
			mlaccel_checker_inst.close_test(test_name);
		end
		mlaccel_checker_inst.report_counts();
		if (error_count == 0 && file_ok) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		@(posedge clock);
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("run stopped after %0d cycles without finishing", cycles);
		$display("Errors found");
		$finish;
	end

endmodule

/* testbench/mlaccel_tests.txt */
# m word_addr data | t name | c opcode caddr maddr | w word_addr byte_enables data
# opcode and caddr are decimal, all other numbers are hex
m 10 0101010101010101
m 11 ff01ff01ff01ff01
m 12 1010101010101010
m 13 f0f0f0f0f0f0f0f0
m 20 0807060504030201
m 21 7f7f7f7f7f7f7f7f
m 22 0101010101010101
t reset_state
t dot_product
c 5 0 10
c 6 0 11
c 42 0 20
c 16 0 800
w 100 03 000000000000fc24
t accumulate
c 5 1 12
c 6 1 13
c 42 0 20
c 40 0 20
c 40 0 20
c 16 4 808
w 101 03 000000000000ff06
c 40 1 21
c 16 4 810
w 102 03 000000000000807f
t relu_units
c 42 0 20
c 20 0 830
w 106 03 0000000000000024
c 17 0 83a
w 107 04 0000000000240000
c 18 0 845
w 108 40 00fc000000000000
c 22 0 847
c 21 0 84f
w 109 80 2400000000000000
c 22 0 860
w 10c 02 0000000000000000
t pointers
c 8 0 20
c 42 0 1
c 14 2 0
c 15 511 0
c 9 0 1
c 40 0 1
c 12 0 900
c 13 0 3
c 16 3 8
w 121 18 000000f07f000000
c 8 0 0
c 14 0 0
c 12 0 0
t back_to_back
c 42 0 20
c 40 0 20
c 40 0 20
c 16 4 818
w 103 03 000000000000ff06
c 40 1 21
c 16 4 820
w 104 03 000000000000807f
c 42 0 20
c 40 0 20
c 40 0 20
c 16 4 828
w 105 03 000000000000ff06

/* all.f */
+incdir+include
rtl/mlaccel_pkg.sv
rtl/mlaccel_issue.sv
rtl/mlaccel_coeff_store.sv
rtl/mlaccel_mac_array.sv
rtl/mlaccel_store_unit.sv
rtl/mlaccel_compute.sv
testbench/mlaccel_checker.sv
testbench/mlaccel_tb.sv

/* Bender.yml */
package:
  name: mlaccel

sources:
  - include_dirs:
      - include
    files:
      - rtl/mlaccel_pkg.sv
      - rtl/mlaccel_issue.sv
      - rtl/mlaccel_coeff_store.sv
      - rtl/mlaccel_mac_array.sv
      - rtl/mlaccel_store_unit.sv
      - rtl/mlaccel_compute.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mlaccel_checker.sv
      - testbench/mlaccel_tb.sv
